//--- verilog/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

    // instruction fields
    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

    // datapath mux selects and codes
    typedef logic [1:0] aluSrcB_t;
    typedef logic [1:0] regDst_t;
    typedef logic [1:0] shiftQnt_t;
    typedef logic [1:0] shiftReg_t;
    typedef logic [2:0] iorD_t;
    typedef logic [2:0] aluOp_t;
    typedef logic [2:0] pcSrc_t;
    typedef logic [2:0] shiftType_t;
    typedef logic [3:0] memtoReg_t;

    localparam opcode_t op0     = 6'h00;
    localparam opcode_t opAddi  = 6'h08;
    localparam opcode_t opAddiu = 6'h09;
    localparam opcode_t opLb    = 6'h20;
    localparam opcode_t opLh    = 6'h21;
    localparam opcode_t opLw    = 6'h23;
    localparam opcode_t opSb    = 6'h28;
    localparam opcode_t opSh    = 6'h29;
    localparam opcode_t opSw    = 6'h2b;

    localparam funct_t functSll = 6'h00;
    localparam funct_t functSrl = 6'h02;
    localparam funct_t functSra = 6'h03;
    localparam funct_t functAdd = 6'h20;

    localparam aluOp_t aluOpAdd = 3'd1;
    localparam aluOp_t aluOpSub = 3'd2;

    localparam iorD_t iorDPc       = 3'd0;
    localparam iorD_t iorDAlu      = 3'd1;
    localparam iorD_t iorDBadOp    = 3'd2; // trap vector for undefined opcode
    localparam iorD_t iorDOverflow = 3'd3;

    localparam pcSrc_t pcSrcAlu  = 3'd0;
    localparam pcSrc_t pcSrcTrap = 3'd3; // handler address from mdr

    localparam shiftType_t shiftLoad       = 3'd1;
    localparam shiftType_t shiftLeft       = 3'd2;
    localparam shiftType_t shiftRightLogic = 3'd3;
    localparam shiftType_t shiftRightArith = 3'd4;

    typedef enum logic [2:0] {
        clsAdd,
        clsImm,
        clsMem,
        clsShift,
        clsUndef
    } instrClass_t;

    typedef enum logic [1:0] {
        widthWord,
        widthHalf,
        widthByte
    } memWidth_t;

    typedef enum logic [4:0] {
        stInit,
        stFetch, stMemWait, stIrLoad, stDecode,
        stAddExec, stAddWrite,
        stImmExec, stImmWrite,
        stAddrCalc, stStoreWord, stMemRead, stMdrWait, stMdrLoad, stLoadWrite, stStorePart,
        stShiftLoad, stShiftOp, stShiftWrite,
        stOvfTrap, stBadOpTrap, stTrapWait, stTrapLoad, stTrapJump
    } ctrlState_t;

    typedef struct packed {
        instrClass_t cls;
        memWidth_t   width;
        logic        isStore;
        logic        trapOnOverflow;
        shiftType_t  shiftType;
    } decodeInfo_t;

    typedef struct packed {
        logic       pcWrite;
        logic       wdSrc;
        logic       memWrite;
        logic       irWrite;
        logic       regWrite;
        logic       regALoad;
        logic       regBLoad;
        logic       aluSrcA;
        logic       epcWrite;
        logic       aluOutWrite;
        logic       twoBytes;
        logic       store;
        logic       mdrLoad;
        regDst_t    regDst;
        aluSrcB_t   aluSrcB;
        shiftQnt_t  shiftQnt;
        shiftReg_t  shiftReg;
        iorD_t      iorD;
        aluOp_t     aluOp;
        pcSrc_t     pcSrc;
        shiftType_t shiftType;
        memtoReg_t  memtoReg;
    } ctrlWord_t;

endpackage

`default_nettype wire

//--- verilog/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
    input  wire ctrlPkg::opcode_t opcode,
    input  wire ctrlPkg::funct_t  funct,
    output ctrlPkg::decodeInfo_t  info
);

    always_comb begin
        info.cls            = ctrlPkg::clsUndef;
        info.width          = ctrlPkg::widthWord;
        info.isStore        = 1'b0;
        info.trapOnOverflow = 1'b0;
        info.shiftType      = '0;

        case (opcode)
            ctrlPkg::op0: begin
                case (funct)
                    ctrlPkg::functAdd: begin
                        info.cls            = ctrlPkg::clsAdd;
                        info.trapOnOverflow = 1'b1;
                    end
                    ctrlPkg::functSll: begin
                        info.cls       = ctrlPkg::clsShift;
                        info.shiftType = ctrlPkg::shiftLeft;
                    end
                    ctrlPkg::functSrl: begin
                        info.cls       = ctrlPkg::clsShift;
                        info.shiftType = ctrlPkg::shiftRightLogic;
                    end
                    ctrlPkg::functSra: begin
                        info.cls       = ctrlPkg::clsShift;
                        info.shiftType = ctrlPkg::shiftRightArith;
                    end
                    default: info.cls = ctrlPkg::clsUndef;
                endcase
            end
            ctrlPkg::opAddi: begin
                info.cls            = ctrlPkg::clsImm;
                info.trapOnOverflow = 1'b1;
            end
            ctrlPkg::opAddiu: info.cls = ctrlPkg::clsImm; // never traps
            ctrlPkg::opLw: info.cls = ctrlPkg::clsMem;
            ctrlPkg::opLh: begin
                info.cls   = ctrlPkg::clsMem;
                info.width = ctrlPkg::widthHalf;
            end
            ctrlPkg::opLb: begin
                info.cls   = ctrlPkg::clsMem;
                info.width = ctrlPkg::widthByte;
            end
            ctrlPkg::opSw: begin
                info.cls     = ctrlPkg::clsMem;
                info.isStore = 1'b1;
            end
            ctrlPkg::opSh: begin
                info.cls     = ctrlPkg::clsMem;
                info.width   = ctrlPkg::widthHalf;
                info.isStore = 1'b1;
            end
            ctrlPkg::opSb: begin
                info.cls     = ctrlPkg::clsMem;
                info.width   = ctrlPkg::widthByte;
                info.isStore = 1'b1;
            end
            default: info.cls = ctrlPkg::clsUndef;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/cycleSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module cycleSequencer (
    input  wire clk,
    input  wire rstN,
    input  wire overflow,
    input  wire ctrlPkg::decodeInfo_t info,
    output ctrlPkg::ctrlState_t state
);

    ctrlPkg::ctrlState_t nextState;
    logic ovfTrap;
    logic wordStore;

    assign ovfTrap   = overflow && info.trapOnOverflow; // addiu ignores overflow
    assign wordStore = info.isStore && (info.width == ctrlPkg::widthWord);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= ctrlPkg::stInit;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = ctrlPkg::stInit;
        case (state)
            ctrlPkg::stInit:    nextState = ctrlPkg::stFetch;

            // common cycles
            ctrlPkg::stFetch:   nextState = ctrlPkg::stMemWait;
            ctrlPkg::stMemWait: nextState = ctrlPkg::stIrLoad;
            ctrlPkg::stIrLoad:  nextState = ctrlPkg::stDecode;
            ctrlPkg::stDecode: begin
                case (info.cls)
                    ctrlPkg::clsAdd:   nextState = ctrlPkg::stAddExec;
                    ctrlPkg::clsImm:   nextState = ctrlPkg::stImmExec;
                    ctrlPkg::clsMem:   nextState = ctrlPkg::stAddrCalc;
                    ctrlPkg::clsShift: nextState = ctrlPkg::stShiftLoad;
                    default:           nextState = ctrlPkg::stBadOpTrap;
                endcase
            end

            ctrlPkg::stAddExec: begin
                nextState = ovfTrap ? ctrlPkg::stOvfTrap : ctrlPkg::stAddWrite;
            end
            ctrlPkg::stAddWrite: nextState = ctrlPkg::stFetch;
            ctrlPkg::stImmExec: begin
                nextState = ovfTrap ? ctrlPkg::stOvfTrap : ctrlPkg::stImmWrite;
            end
            ctrlPkg::stImmWrite: nextState = ctrlPkg::stFetch;

            // memory path, partial stores read the word first
            ctrlPkg::stAddrCalc: begin
                if (wordStore) begin
                    nextState = ctrlPkg::stStoreWord;
                end else begin
                    nextState = ctrlPkg::stMemRead;
                end
            end
            ctrlPkg::stStoreWord: nextState = ctrlPkg::stFetch;
            ctrlPkg::stMemRead:   nextState = ctrlPkg::stMdrWait;
            ctrlPkg::stMdrWait:   nextState = ctrlPkg::stMdrLoad;
            ctrlPkg::stMdrLoad: begin
                if (info.isStore) begin
                    nextState = ctrlPkg::stStorePart;
                end else begin
                    nextState = ctrlPkg::stLoadWrite;
                end
            end
            ctrlPkg::stLoadWrite: nextState = ctrlPkg::stFetch;
            ctrlPkg::stStorePart: nextState = ctrlPkg::stFetch;

            ctrlPkg::stShiftLoad:  nextState = ctrlPkg::stShiftOp;
            ctrlPkg::stShiftOp:    nextState = ctrlPkg::stShiftWrite;
            ctrlPkg::stShiftWrite: nextState = ctrlPkg::stFetch;

            // both traps share the handler fetch
            ctrlPkg::stOvfTrap:   nextState = ctrlPkg::stTrapWait;
            ctrlPkg::stBadOpTrap: nextState = ctrlPkg::stTrapWait;
            ctrlPkg::stTrapWait:  nextState = ctrlPkg::stTrapLoad;
            ctrlPkg::stTrapLoad:  nextState = ctrlPkg::stTrapJump;
            ctrlPkg::stTrapJump:  nextState = ctrlPkg::stFetch;

            default: nextState = ctrlPkg::stInit;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/controlEncoder.sv
`timescale 1ns/1ps
`default_nettype none

module controlEncoder (
    input  wire rstN,
    input  wire ctrlPkg::ctrlState_t  state,
    input  wire ctrlPkg::decodeInfo_t info,
    output ctrlPkg::ctrlWord_t ctrl
);

    ctrlPkg::ctrlWord_t word;
    logic isHalf;
    logic isWord;

    assign isHalf = (info.width == ctrlPkg::widthHalf);
    assign isWord = (info.width == ctrlPkg::widthWord);

    always_comb begin
        word = '0;
        case (state)
            ctrlPkg::stInit: begin
                word.regWrite = 1'b1; // clear register file entry
                word.regDst   = 2'd3;
                word.memtoReg = 4'd7;
            end
            ctrlPkg::stFetch: begin
                word.pcWrite = 1'b1; // pc + 4
                word.pcSrc   = ctrlPkg::pcSrcAlu;
                word.aluSrcB = 2'd1;
                word.aluOp   = ctrlPkg::aluOpAdd;
                word.iorD    = ctrlPkg::iorDPc;
            end
            ctrlPkg::stIrLoad: word.irWrite = 1'b1;
            ctrlPkg::stDecode: begin
                word.regALoad    = 1'b1;
                word.regBLoad    = 1'b1;
                word.aluOutWrite = 1'b1; // branch target, unused here
                word.aluSrcB     = 2'd3;
                word.aluOp       = ctrlPkg::aluOpAdd;
            end

            ctrlPkg::stAddExec: begin
                word.aluSrcA     = 1'b1;
                word.aluOp       = ctrlPkg::aluOpAdd;
                word.aluOutWrite = 1'b1;
            end
            ctrlPkg::stImmExec, ctrlPkg::stAddrCalc: begin
                word.aluSrcA     = 1'b1;
                word.aluSrcB     = 2'd2; // sign extended immediate
                word.aluOp       = ctrlPkg::aluOpAdd;
                word.aluOutWrite = 1'b1;
            end
            ctrlPkg::stAddWrite, ctrlPkg::stShiftWrite: begin
                word.regWrite = 1'b1;
                word.regDst   = 2'd1; // rd
                word.memtoReg = (state == ctrlPkg::stShiftWrite) ? 4'd3 : 4'd0;
            end
            ctrlPkg::stImmWrite: word.regWrite = 1'b1;

            ctrlPkg::stStoreWord: begin
                word.memWrite = 1'b1;
                word.iorD     = ctrlPkg::iorDAlu;
            end
            ctrlPkg::stMemRead, ctrlPkg::stMdrWait: word.iorD = ctrlPkg::iorDAlu;
            ctrlPkg::stMdrLoad: begin
                word.iorD    = ctrlPkg::iorDAlu;
                word.mdrLoad = 1'b1;
            end
            ctrlPkg::stLoadWrite: begin
                word.regWrite = 1'b1;
                word.memtoReg = isWord ? 4'd1 : 4'd2;
                word.twoBytes = isHalf;
            end
            ctrlPkg::stStorePart: begin
                // merge rt into the word just read
                word.memWrite = 1'b1;
                word.iorD     = ctrlPkg::iorDAlu;
                word.wdSrc    = 1'b1;
                word.store    = 1'b1;
                word.twoBytes = isHalf;
            end

            ctrlPkg::stShiftLoad: begin
                word.shiftQnt  = 2'd1; // shamt field
                word.shiftReg  = 2'd2;
                word.shiftType = ctrlPkg::shiftLoad;
            end
            ctrlPkg::stShiftOp: word.shiftType = info.shiftType;

            ctrlPkg::stOvfTrap, ctrlPkg::stBadOpTrap: begin
                // epc gets pc - 4
                word.epcWrite = 1'b1;
                word.aluSrcB  = 2'd1;
                word.aluOp    = ctrlPkg::aluOpSub;
                if (state == ctrlPkg::stOvfTrap) begin
                    word.iorD = ctrlPkg::iorDOverflow;
                end else begin
                    word.iorD = ctrlPkg::iorDBadOp;
                end
            end
            ctrlPkg::stTrapLoad: word.mdrLoad = 1'b1;
            ctrlPkg::stTrapJump: begin
                word.pcWrite = 1'b1;
                word.pcSrc   = ctrlPkg::pcSrcTrap;
            end
            default: word = '0;
        endcase
    end

    assign ctrl = rstN ? word : '0;

endmodule

`default_nettype wire

//--- verilog/multicycleControl.sv
`timescale 1ns/1ps
`default_nettype none

module multicycleControl (
    input  wire clk,
    input  wire rstN,
    input  wire ctrlPkg::opcode_t opcode,
    input  wire ctrlPkg::funct_t  funct,
    input  wire overflow,
    output ctrlPkg::ctrlWord_t ctrl
);

    ctrlPkg::decodeInfo_t info;
    ctrlPkg::ctrlState_t  state;

    instrDecoder instrDecoder_inst (
        .opcode (opcode),
        .funct  (funct),
        .info   (info)
    );

    cycleSequencer cycleSequencer_inst (
        .clk      (clk),
        .rstN     (rstN),
        .overflow (overflow),
        .info     (info),
        .state    (state)
    );

    controlEncoder controlEncoder_inst (
        .rstN  (rstN),
        .state (state),
        .info  (info),
        .ctrl  (ctrl)
    );

endmodule

`default_nettype wire

//--- tb/multicycleControl_checker.sv
`timescale 1ns/1ps
`default_nettype none

module multicycleControl_checker (
    input wire clk,
    input wire rstN,
    input wire ctrlPkg::ctrlWord_t ctrl
);

    int failCount = 0; // assertion failures so far

    // pc and register file never updated in the same cycle
    pcWriteNotRegWrite: assert property (
        @(posedge clk) disable iff (!rstN)
        !(ctrl.pcWrite && ctrl.regWrite)
    ) else begin
        failCount++;
        $error("pcWrite and regWrite high in the same cycle");
    end

    memWriteUsesAlu: assert property (
        @(posedge clk) disable iff (!rstN)
        ctrl.memWrite |-> (ctrl.iorD == ctrlPkg::iorDAlu)
    ) else begin
        failCount++;
        $error("memWrite without iorD selecting the ALU address");
    end

    // epc written once per trap
    epcWriteSingle: assert property (
        @(posedge clk) disable iff (!rstN)
        ctrl.epcWrite |=> !ctrl.epcWrite
    ) else begin
        failCount++;
        $error("epcWrite held for two cycles");
    end

endmodule

`default_nettype wire

//--- tb/multicycleControl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module multicycleControl_tb;

    localparam int clkPeriod      = 4;
    localparam int resetCycles    = 8;
    localparam int maxInstrCycles = 16;
    localparam int undefDraws     = 4;
    // fetch to fetch lengths of every test, reset included
    localparam int testCycles = 2 + 4 * 6 + 2 * 9 + 6 + 5 * 9 + 3 * 7 + undefDraws * 8 + 8;
    localparam int watchdogNs = (testCycles * 2 + resetCycles) * clkPeriod;

    logic clk;
    logic rstN;
    ctrlPkg::opcode_t opcode;
    ctrlPkg::funct_t funct;
    logic overflow;
    ctrlPkg::ctrlWord_t ctrl;

    int wordErrors;
    int lengthErrors;
    int otherErrors;
    integer seed = 32'hc14c_bbac;
    ctrlPkg::ctrlWord_t seen[$]; // words from one fetch up to the next

    multicycleControl multicycleControl_inst (
        .clk      (clk),
        .rstN     (rstN),
        .opcode   (opcode),
        .funct    (funct),
        .overflow (overflow),
        .ctrl     (ctrl)
    );

    bind multicycleControl multicycleControl_checker multicycleControl_checker_inst (
        .clk  (clk),
        .rstN (rstN),
        .ctrl (ctrl)
    );

    initial clk = 1'b0;
    always #(clkPeriod / 2) clk = ~clk;

    function automatic ctrlPkg::ctrlWord_t fetchWord();
        ctrlPkg::ctrlWord_t w;
        w = '0;
        w.pcWrite = 1'b1;
        w.pcSrc   = ctrlPkg::pcSrcAlu;
        w.aluSrcB = 2'd1;
        w.aluOp   = ctrlPkg::aluOpAdd;
        w.iorD    = ctrlPkg::iorDPc;
        return w;
    endfunction

    function automatic ctrlPkg::ctrlWord_t initWord();
        ctrlPkg::ctrlWord_t w;
        w = '0;
        w.regWrite = 1'b1;
        w.regDst   = 2'd3;
        w.memtoReg = 4'd7;
        return w;
    endfunction

    function automatic ctrlPkg::ctrlWord_t irLoadWord();
        ctrlPkg::ctrlWord_t w;
        w = '0;
        w.irWrite = 1'b1;
        return w;
    endfunction

    function automatic ctrlPkg::ctrlWord_t writeBackWord(input ctrlPkg::regDst_t dst,
                                                       input ctrlPkg::memtoReg_t src,
                                                       input logic half);
        ctrlPkg::ctrlWord_t w;
        w = '0;
        w.regWrite = 1'b1;
        w.regDst   = dst;
        w.memtoReg = src;
        w.twoBytes = half;
        return w;
    endfunction

    function automatic ctrlPkg::ctrlWord_t storeFullWord();
        ctrlPkg::ctrlWord_t w;
        w = '0;
        w.memWrite = 1'b1;
        w.iorD     = ctrlPkg::iorDAlu;
        return w;
    endfunction

    function automatic ctrlPkg::ctrlWord_t storePartWord(input logic half);
        ctrlPkg::ctrlWord_t w;
        w = '0;
        w.memWrite = 1'b1;
        w.iorD     = ctrlPkg::iorDAlu;
        w.wdSrc    = 1'b1;
        w.store    = 1'b1;
        w.twoBytes = half;
        return w;
    endfunction

    function automatic ctrlPkg::ctrlWord_t trapEntryWord(input ctrlPkg::iorD_t cause);
        ctrlPkg::ctrlWord_t w;
        w = '0;
        w.epcWrite = 1'b1;
        w.aluSrcB  = 2'd1;
        w.aluOp    = ctrlPkg::aluOpSub;
        w.iorD     = cause;
        return w;
    endfunction

    function automatic ctrlPkg::ctrlWord_t trapJumpWord();
        ctrlPkg::ctrlWord_t w;
        w = '0;
        w.pcWrite = 1'b1;
        w.pcSrc   = ctrlPkg::pcSrcTrap;
        return w;
    endfunction

    function automatic ctrlPkg::ctrlWord_t shiftOpWord(input ctrlPkg::shiftType_t kind);
        ctrlPkg::ctrlWord_t w;
        w = '0;
        w.shiftType = kind;
        return w;
    endfunction

    function automatic ctrlPkg::ctrlWord_t seenAt(input int idx);
        if (idx < 0 || idx >= seen.size()) begin
            return '0; // index past the end of a short run
        end
        return seen[idx];
    endfunction

    task automatic checkWord(input string name, input ctrlPkg::ctrlWord_t expected,
                             input ctrlPkg::ctrlWord_t actual);
        if (actual !== expected) begin
            wordErrors++;
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic checkLength(input string name, input int expected, input int actual);
        if (actual != expected) begin
            lengthErrors++;
            $display("[FAIL] %s length: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    // entered at the falling edge of a fetch cycle
    task automatic runInstr(input string name, input ctrlPkg::opcode_t op,
                            input ctrlPkg::funct_t fn, input logic ovf, input int expLength);
        ctrlPkg::ctrlWord_t w;
        int count;
        bit done;
        w = ctrl;
        checkWord({name, " fetch"}, fetchWord(), w);
        seen.delete();
        seen.push_back(w);
        opcode   = op;
        funct    = fn;
        overflow = ovf;
        count    = 1;
        done     = 1'b0;
        while (!done && count <= maxInstrCycles) begin
            @(negedge clk);
            w = ctrl;
            if (w.pcWrite && w.pcSrc == ctrlPkg::pcSrcAlu) begin
                done = 1'b1;
            end else begin
                seen.push_back(w);
                count++;
            end
        end
        if (!done) begin
            otherErrors++;
            $display("%s: no fetch word seen within %0d cycles", name, maxInstrCycles);
        end
        checkLength(name, expLength, count);
        checkWord({name, " ir load"}, irLoadWord(), seenAt(2));
    endtask

    task automatic resetSequence();
        int i;
        for (i = 0; i < resetCycles; i++) begin
            @(negedge clk);
            checkWord("reset held", '0, ctrl);
        end
        rstN = 1'b1;
        #1;
        checkWord("reset init", initWord(), ctrl);
        @(negedge clk);
    endtask

    task automatic arithInstr(input string name, input ctrlPkg::opcode_t op,
                              input ctrlPkg::funct_t fn, input logic ovf,
                              input ctrlPkg::regDst_t dst);
        runInstr(name, op, fn, ovf, 6);
        checkWord({name, " write"}, writeBackWord(dst, 4'd0, 1'b0), seenAt(5));
    endtask

    task automatic overflowTrap(input string name, input ctrlPkg::opcode_t op,
                                input ctrlPkg::funct_t fn);
        runInstr(name, op, fn, 1'b1, 9);
        checkWord({name, " epc"}, trapEntryWord(ctrlPkg::iorDOverflow), seenAt(5));
        checkWord({name, " jump"}, trapJumpWord(), seenAt(8));
    endtask

    task automatic memoryAccess(input string name, input ctrlPkg::opcode_t op,
                                input int expLength, input ctrlPkg::ctrlWord_t expLast);
        runInstr(name, op, 6'h00, 1'b0, expLength);
        checkWord({name, " last"}, expLast, seenAt(expLength - 1));
    endtask

    task automatic shiftInstr(input string name, input ctrlPkg::funct_t fn,
                              input ctrlPkg::shiftType_t kind);
        runInstr(name, ctrlPkg::op0, fn, 1'b0, 7);
        checkWord({name, " shift"}, shiftOpWord(kind), seenAt(5));
        checkWord({name, " write"}, writeBackWord(2'd1, 4'd3, 1'b0), seenAt(6));
    endtask

    task automatic undefinedInstr(input string name, input ctrlPkg::opcode_t op,
                                  input ctrlPkg::funct_t fn);
        runInstr(name, op, fn, 1'b0, 8);
        checkWord({name, " epc"}, trapEntryWord(ctrlPkg::iorDBadOp), seenAt(4));
        checkWord({name, " jump"}, trapJumpWord(), seenAt(7));
    endtask

    task automatic drawUndefFunct(output ctrlPkg::funct_t fn);
        int draw;
        do begin
            draw = $random(seed);
            fn   = draw[5:0];
        end while (fn == ctrlPkg::functAdd || fn == ctrlPkg::functSll ||
                   fn == ctrlPkg::functSrl || fn == ctrlPkg::functSra);
    endtask

    initial begin
        ctrlPkg::funct_t fn;
        int i;
        int assertErrors;
        rstN         = 1'b0;
        opcode       = '0;
        funct        = '0;
        overflow     = 1'b0;
        wordErrors   = 0;
        lengthErrors = 0;
        otherErrors  = 0;

        resetSequence();
        arithInstr("add", ctrlPkg::op0, ctrlPkg::functAdd, 1'b0, 2'd1);
        arithInstr("addi", ctrlPkg::opAddi, 6'h00, 1'b0, 2'd0);
        arithInstr("addiu", ctrlPkg::opAddiu, 6'h00, 1'b0, 2'd0);
        arithInstr("addiu overflow", ctrlPkg::opAddiu, 6'h00, 1'b1, 2'd0); // no trap
        overflowTrap("add overflow", ctrlPkg::op0, ctrlPkg::functAdd);
        overflowTrap("addi overflow", ctrlPkg::opAddi, 6'h00);

        memoryAccess("sw", ctrlPkg::opSw, 6, storeFullWord());
        memoryAccess("lw", ctrlPkg::opLw, 9, writeBackWord(2'd0, 4'd1, 1'b0));
        memoryAccess("lh", ctrlPkg::opLh, 9, writeBackWord(2'd0, 4'd2, 1'b1));
        memoryAccess("lb", ctrlPkg::opLb, 9, writeBackWord(2'd0, 4'd2, 1'b0));
        memoryAccess("sh", ctrlPkg::opSh, 9, storePartWord(1'b1));
        memoryAccess("sb", ctrlPkg::opSb, 9, storePartWord(1'b0));

        shiftInstr("sll", ctrlPkg::functSll, ctrlPkg::shiftLeft);
        shiftInstr("sra", ctrlPkg::functSra, ctrlPkg::shiftRightArith);
        shiftInstr("srl", ctrlPkg::functSrl, ctrlPkg::shiftRightLogic);

        for (i = 0; i < undefDraws; i++) begin
            drawUndefFunct(fn);
            undefinedInstr($sformatf("undefined funct %h", fn), ctrlPkg::op0, fn);
        end
        undefinedInstr("unused opcode", 6'h0f, 6'h00); // lui, not in this subset

        assertErrors = multicycleControl_inst.multicycleControl_checker_inst.failCount;
        $display("errors: word %0d, length %0d, other %0d, assertion %0d",
                 wordErrors, lengthErrors, otherErrors, assertErrors);
        if (wordErrors + lengthErrors + otherErrors + assertErrors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(watchdogNs);
        $display("simulation hung: tests not finished after %0d ns", watchdogNs);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- multicycleControl.f
verilog/ctrlPkg.sv
verilog/instrDecoder.sv
verilog/cycleSequencer.sv
verilog/controlEncoder.sv
verilog/multicycleControl.sv
tb/multicycleControl_checker.sv
tb/multicycleControl_tb.sv

//--- Bender.yml
package:
  name: multicycleControl

sources:
  - files:
      - verilog/ctrlPkg.sv
      - verilog/instrDecoder.sv
      - verilog/cycleSequencer.sv
      - verilog/controlEncoder.sv
      - verilog/multicycleControl.sv
  - target: test
    files:
      - tb/multicycleControl_checker.sv
      - tb/multicycleControl_tb.sv
